// ==== include/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Data path and PC width.
`define EXEC_XLEN 32

// Destination register address, 32 integer plus 32 float registers.
`define EXEC_RD_W 6

// Cycles from FPU start to fin.
`define EXEC_FPU_CYCLES 4

`endif

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,   // Compares from here on also set the flag.
        alu_sltu = 4'd9,
        alu_eq   = 4'd10,
        alu_ne   = 4'd11,
        alu_ge   = 4'd12,
        alu_geu  = 4'd13
    } alu_op_e;

    typedef enum logic [1:0] {
        fpu_add = 2'd0,
        fpu_sub = 2'd1,
        fpu_mul = 2'd2
    } fpu_op_e;

    // Const A is 0 on source 0 and 4 on source 1.
    typedef enum logic [1:0] {
        src_reg    = 2'd0,
        src_const  = 2'd1,
        src_pc_imm = 2'd2,   // PC on source 0, immediate on source 1.
        src_zero   = 2'd3
    } src_sel_e;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_cond = 2'd1,   // Taken when the ALU flag is set.
        br_jal  = 2'd2,
        br_jalr = 2'd3
    } branch_e;

endpackage

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none
`include "exec_config.svh"

package pipe_pkg;

    import isa_pkg::*;

    // Decoded instruction as it moves between stages.
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] imm;
        logic [`EXEC_RD_W-1:0] rd;
        src_sel_e              src0;
        src_sel_e              src1;
        alu_op_e               aluop;
        fpu_op_e               fpuop;
        logic                  aluorfpu;   // High selects the FPU.
        branch_e               branchjump;
        logic                  regwrite;
        logic                  memread;
    } inst_t;

endpackage

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module alu
    import isa_pkg::*;
(
    input  wire  [`EXEC_XLEN-1:0] src0,
    input  wire  [`EXEC_XLEN-1:0] src1,
    input  wire  alu_op_e         aluop,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  flag
);

    logic [4:0] shamt;

    assign shamt = src1[4:0];

    always_comb begin
        flag = 1'b0;
        case (aluop)
            alu_slt:  flag = $signed(src0) < $signed(src1);
            alu_sltu: flag = src0 < src1;
            alu_eq:   flag = src0 == src1;
            alu_ne:   flag = src0 != src1;
            alu_ge:   flag = $signed(src0) >= $signed(src1);
            alu_geu:  flag = src0 >= src1;
            default:  flag = 1'b0;
        endcase
    end

    always_comb begin
        case (aluop)
            alu_add: result = src0 + src1;
            alu_sub: result = src0 - src1;
            alu_and: result = src0 & src1;
            alu_or:  result = src0 | src1;
            alu_xor: result = src0 ^ src1;
            alu_sll: result = src0 << shamt;
            alu_srl: result = src0 >> shamt;
            alu_sra: result = $signed(src0) >>> shamt;
            alu_slt,
            alu_sltu,
            alu_eq,
            alu_ne,
            alu_ge,
            alu_geu: begin
                // Compares write 0 or 1.
                result = {{(`EXEC_XLEN-1){1'b0}}, flag};
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/fpu.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module fpu
    import isa_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   start,
    input  wire  fpu_op_e         fpuop,
    input  wire  [`EXEC_XLEN-1:0] src0,
    input  wire  [`EXEC_XLEN-1:0] src1,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  fin
);

    localparam int cycles = `EXEC_FPU_CYCLES;
    localparam int cnt_w = $clog2(cycles);

    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic             accept;

    logic [31:0] a_r, b_r;   // Operands, b already sign-flipped for fsub.
    fpu_op_e     op_r;

    logic        u_sign_a, u_sign_b;
    logic [7:0]  u_exp_a, u_exp_b;
    logic [23:0] u_man_a, u_man_b;   // Hidden bit included.

    logic               big_is_a;
    logic [7:0]         exp_diff;
    logic [47:0]        man_big, man_small, product;
    logic               al_sign, al_zero;
    logic signed [10:0] al_exp;
    logic [48:0]        al_man;

    logic               s2_sign, s2_zero;
    logic signed [10:0] s2_exp;
    logic [48:0]        s2_man;

    logic [5:0]         lead;
    logic [48:0]        shifted;
    logic signed [10:0] norm_exp;

    logic        n_sign;
    logic [7:0]  n_exp;
    logic [22:0] n_man;

    assign fin = busy && (cnt == cnt_w'(cycles - 1));
    assign accept = start && !busy;   // Only an idle unit starts, so a held enable waits.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (fin) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_r  <= src0[31:0];
            b_r  <= {src1[31] ^ (fpuop == fpu_sub), src1[30:0]};
            op_r <= fpuop;
        end
    end

    // Multiply and alignment of the smaller addend.
    always_comb begin
        big_is_a  = {u_exp_a, u_man_a} >= {u_exp_b, u_man_b};
        man_big   = big_is_a ? {u_man_a, 24'b0} : {u_man_b, 24'b0};
        exp_diff  = big_is_a ? u_exp_a - u_exp_b : u_exp_b - u_exp_a;
        man_small = (big_is_a ? {u_man_b, 24'b0} : {u_man_a, 24'b0}) >> exp_diff;
        product   = u_man_a * u_man_b;
        if (op_r == fpu_mul) begin
            al_sign = u_sign_a ^ u_sign_b;
            al_exp  = 11'(u_exp_a) + 11'(u_exp_b) - 11'sd126;   // Product MSB sits at bit 46.
            al_man  = {1'b0, product};
            al_zero = (u_man_a == '0) || (u_man_b == '0);
        end else begin
            al_sign = big_is_a ? u_sign_a : u_sign_b;
            al_exp  = 11'(big_is_a ? u_exp_a : u_exp_b);
            if (u_sign_a == u_sign_b)
                al_man = {1'b0, man_big} + {1'b0, man_small};
            else
                al_man = {1'b0, man_big} - {1'b0, man_small};
            al_zero = (al_man == '0);
        end
    end

    // Leading one goes back to bit 47.
    always_comb begin
        lead = '0;
        for (int i = 0; i <= 48; i++) begin
            if (s2_man[i])
                lead = 6'(i);
        end
        if (s2_man[48])
            shifted = s2_man >> 1;
        else
            shifted = s2_man << (6'd47 - lead);
        norm_exp = s2_exp + 11'(lead) - 11'sd47;
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            u_sign_a <= a_r[31];
            u_exp_a  <= a_r[30:23];
            u_man_a  <= (a_r[30:23] == '0) ? 24'b0 : {1'b1, a_r[22:0]};   // Flush denormals.
            u_sign_b <= b_r[31];
            u_exp_b  <= b_r[30:23];
            u_man_b  <= (b_r[30:23] == '0) ? 24'b0 : {1'b1, b_r[22:0]};

            s2_sign <= al_sign;
            s2_zero <= al_zero;
            s2_exp  <= al_exp;
            s2_man  <= al_man;

            if (s2_zero || norm_exp <= 0) begin
                n_sign <= 1'b0;
                n_exp  <= '0;
                n_man  <= '0;
            end else if (norm_exp >= 255) begin
                n_sign <= s2_sign;   // Saturate to infinity.
                n_exp  <= 8'hff;
                n_man  <= '0;
            end else begin
                n_sign <= s2_sign;
                n_exp  <= norm_exp[7:0];
                n_man  <= shifted[46:24];   // Low bits dropped, so truncation.
            end
        end
    end

    assign result = {n_sign, n_exp, n_man};

endmodule

`default_nettype wire

// ==== src/branch_unit.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module branch_unit (
    input  wire  isa_pkg::branch_e  branchjump,
    input  wire                     flag,
    input  wire  [`EXEC_XLEN-1:0]   pc4,
    input  wire  [`EXEC_XLEN-1:0]   pcimm,
    input  wire  [`EXEC_XLEN-1:0]   pcjalr,
    output logic [`EXEC_XLEN-1:0]   pcnext
);

    logic taken;

    always_comb begin
        case (branchjump)
            isa_pkg::br_cond: taken = flag;
            isa_pkg::br_jal,
            isa_pkg::br_jalr: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken)
            pcnext = pc4;
        else if (branchjump == isa_pkg::br_jalr)
            pcnext = {pcjalr[`EXEC_XLEN-1:1], 1'b0};   // Target LSB cleared.
        else
            pcnext = pcimm;
    end

endmodule

`default_nettype wire

// ==== src/exec.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module exec
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   enable,
    output logic                  fin,
    output logic [`EXEC_RD_W-1:0] rd,
    output logic                  regwrite,
    output logic                  memread,
    output logic                  branchjump_miss,
    input  wire  [`EXEC_XLEN-1:0] rdata0,
    input  wire  [`EXEC_XLEN-1:0] rdata1,
    input  wire  inst_t           inst,
    output logic [`EXEC_XLEN-1:0] pcnext,
    output inst_t                 inst_out,
    output logic [`EXEC_XLEN-1:0] aluresult,
    output logic [`EXEC_XLEN-1:0] result,
    output logic [`EXEC_XLEN-1:0] rdata1_out
);

    logic [`EXEC_XLEN-1:0] src0, src1;
    logic [`EXEC_XLEN-1:0] fpu_result;
    logic [`EXEC_XLEN-1:0] pc4, pcimm, pcjalr;
    logic                  flag;
    logic                  fpu_fin;

    always_comb begin
        case (inst.src0)
            src_reg:    src0 = rdata0;
            src_pc_imm: src0 = inst.pc;
            default:    src0 = '0;   // Const A is zero here.
        endcase
        case (inst.src1)
            src_reg:    src1 = rdata1;
            src_const:  src1 = `EXEC_XLEN'd4;
            src_pc_imm: src1 = inst.imm;
            default:    src1 = '0;
        endcase
    end

    alu alu_i (.src0(src0), .src1(src1), .aluop(inst.aluop), .result(aluresult), .flag(flag));

    fpu fpu_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (enable & inst.aluorfpu),
        .fpuop  (inst.fpuop),
        .src0   (src0),
        .src1   (src1),
        .result (fpu_result),
        .fin    (fpu_fin)
    );

    assign pc4 = inst.pc + `EXEC_XLEN'd4;
    assign pcimm = inst.pc + inst.imm;
    assign pcjalr = rdata0 + inst.imm;

    branch_unit branch_unit_i (
        .branchjump (inst.branchjump),
        .flag       (flag),
        .pc4        (pc4),
        .pcimm      (pcimm),
        .pcjalr     (pcjalr),
        .pcnext     (pcnext)
    );

    // ALU ops finish in the cycle they arrive.
    assign fin = enable & (inst.aluorfpu ? fpu_fin : 1'b1);
    assign result = inst.aluorfpu ? fpu_result : aluresult;
    assign branchjump_miss = pcnext != pc4;

    assign rd = inst.rd;
    assign regwrite = inst.regwrite;
    assign memread = inst.memread;
    assign inst_out = inst;
    assign rdata1_out = rdata1;

endmodule

`default_nettype wire

// ==== verification/exec_assertions.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_assertions
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input wire                   clk,
    input wire                   arst_n,
    input wire                   enable,
    input wire                   fin,
    input wire                   fpu_fin,
    input wire  inst_t           inst,
    input wire  [`EXEC_XLEN-1:0] pcnext,
    input wire                   branchjump_miss
);

    // The FPU only completes work that upstream still holds.
    property fpu_fin_only_when_enabled;
        @(posedge clk) disable iff (!arst_n)
            !enable |-> !fpu_fin;
    endproperty

    // Count starts at the first edge that sees enable.
    property fpu_latency;
        @(posedge clk) disable iff (!arst_n)
            $rose(enable) && inst.aluorfpu |-> !fin [*`EXEC_FPU_CYCLES] ##1 fin;
    endproperty

    property miss_only_on_branch;
        @(posedge clk) disable iff (!arst_n)
            enable && branchjump_miss |-> inst.branchjump != br_none;
    endproperty

    assert property (fpu_fin_only_when_enabled)
        else $error("FPU finished while enable is low");

    assert property (fpu_latency)
        else $error("FPU fin did not arrive after the expected number of cycles");

    assert property (miss_only_on_branch)
        else $error("branchjump_miss is high for an instruction that is no branch or jump");

endmodule

`default_nettype wire

// ==== verification/exec_checker.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_checker
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   enable,
    input  wire  inst_t           inst,
    input  wire  [`EXEC_XLEN-1:0] rdata1,
    input  wire                   fin,
    input  wire  [`EXEC_RD_W-1:0] rd,
    input  wire                   regwrite,
    input  wire                   memread,
    input  wire                   branchjump_miss,
    input  wire  [`EXEC_XLEN-1:0] pcnext,
    input  wire  inst_t           inst_out,
    input  wire  [`EXEC_XLEN-1:0] aluresult,
    input  wire  [`EXEC_XLEN-1:0] result,
    input  wire  [`EXEC_XLEN-1:0] rdata1_out,
    input  wire  [`EXEC_XLEN-1:0] exp_result,
    input  wire  [`EXEC_XLEN-1:0] exp_pcnext,
    input  wire                   exp_miss,
    output int                    errors
);

    int wait_cnt;   // Edges seen with enable high and no fin yet.
    int exp_wait;

    task automatic compare_word(input string name, input logic [`EXEC_XLEN-1:0] got,
                                input logic [`EXEC_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    initial errors = 0;

    always @(posedge clk) begin
        if (!arst_n) begin
            wait_cnt = 0;
        end else if (!enable) begin
            wait_cnt = 0;
            if (fin) begin
                $display("ERROR %0t: fin is high while enable is low", $time);
                errors++;
            end
        end else if (!fin) begin
            wait_cnt++;
        end else begin
            exp_wait = inst.aluorfpu ? `EXEC_FPU_CYCLES : 0;
            compare_word("fin latency", wait_cnt, exp_wait);
            compare_word("result", result, exp_result);
            if (!inst.aluorfpu)
                compare_word("aluresult", aluresult, exp_result);
            compare_word("pcnext", pcnext, exp_pcnext);
            compare_word("branchjump_miss", 32'(branchjump_miss), 32'(exp_miss));
            compare_word("rd", 32'(rd), 32'(inst.rd));
            compare_word("regwrite", 32'(regwrite), 32'(inst.regwrite));
            compare_word("memread", 32'(memread), 32'(inst.memread));
            compare_word("rdata1_out", rdata1_out, rdata1);
            if (inst_out !== inst) begin
                $display("ERROR %0t: inst_out is %h, expected %h", $time, inst_out, inst);
                errors++;
            end
            wait_cnt = 0;
        end
    end

endmodule

`default_nettype wire

// ==== verification/exec_tb.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "exec_config.svh"

module exec_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int fin_timeout = 20;
    localparam int n_fields = 16;

    logic                  clk;
    logic                  arst_n;
    logic                  enable;
    inst_t                 inst;
    logic [`EXEC_XLEN-1:0] rdata0, rdata1;
    logic [`EXEC_XLEN-1:0] exp_result, exp_pcnext;
    logic                  exp_miss;

    logic                  fin, regwrite, memread, branchjump_miss;
    logic [`EXEC_RD_W-1:0] rd;
    inst_t                 inst_out;
    logic [`EXEC_XLEN-1:0] pcnext, aluresult, result, rdata1_out;

    int          errors;
    int          timeouts;
    int          cases;
    int          file_errors;
    logic [31:0] fields [n_fields];

    exec exec_i (.*);

    exec_checker exec_checker_i (.*);

    bind exec exec_assertions exec_assertions_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic run_case();
        int cyc;
        bit seen;
        seen = 1'b0;
        @(negedge clk);
        inst.pc         = fields[0];
        inst.imm        = fields[1];
        inst.rd         = fields[2][`EXEC_RD_W-1:0];
        inst.src0       = src_sel_e'(fields[3][1:0]);
        inst.src1       = src_sel_e'(fields[4][1:0]);
        inst.aluop      = alu_op_e'(fields[5][3:0]);
        inst.fpuop      = fpu_op_e'(fields[6][1:0]);
        inst.aluorfpu   = fields[7][0];
        inst.branchjump = branch_e'(fields[8][1:0]);
        inst.regwrite   = fields[9][0];
        inst.memread    = fields[10][0];
        rdata0          = fields[11];
        rdata1          = fields[12];
        exp_result      = fields[13];
        exp_pcnext      = fields[14];
        exp_miss        = fields[15][0];
        enable          = 1'b1;
        for (cyc = 0; cyc < fin_timeout && !seen; cyc++) begin
            @(posedge clk);
            seen = fin;
        end
        if (!seen) begin
            $display("fin never arrived for case %0d", cases);
            timeouts++;
        end
        @(negedge clk);
        enable = 1'b0;
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        arst_n = 1'b0;
        enable = 1'b0;
        inst = '0;
        rdata0 = '0;
        rdata1 = '0;
        exp_result = '0;
        exp_pcnext = '0;
        exp_miss = 1'b0;
        timeouts = 0;
        cases = 0;
        file_errors = 0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (5) @(negedge clk);   // Idle with enable low.
        fd = $fopen("verification/exec_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/exec_cases.txt");
            file_errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0)
                    break;
                if (line.len() == 0 || line[0] == "#")
                    continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fields[0], fields[1], fields[2], fields[3], fields[4],
                            fields[5], fields[6], fields[7], fields[8], fields[9],
                            fields[10], fields[11], fields[12], fields[13], fields[14],
                            fields[15]);
                if (n <= 0)
                    continue;
                if (n != n_fields) begin
                    $display("A line of the cases file has %0d fields instead of %0d", n,
                             n_fields);
                    file_errors++;
                    continue;
                end
                cases++;
                run_case();
            end
            $fclose(fd);
        end
        if (cases == 0) begin
            $display("No cases were read from the cases file");
            file_errors++;
        end
        $display("Ran %0d cases: %0d errors, %0d timeouts, %0d file problems",
                 cases, errors, timeouts, file_errors);
        if (errors == 0 && timeouts == 0 && file_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/isa_pkg.sv
src/pipe_pkg.sv
src/alu.sv
src/fpu.sv
src/branch_unit.sv
src/exec.sv
verification/exec_assertions.sv
verification/exec_checker.sv
verification/exec_tb.sv

// ==== verification/exec_cases.txt ====
# pc imm rd src0 src1 aluop fpuop aluorfpu branchjump regwrite memread rdata0 rdata1
# then expected result pcnext branchjump_miss, all hex
00001000 00000010 05 0 2 0 0 0 0 1 0 00000064 00000000 00000074 00001004 0
00001004 00000000 06 0 0 1 0 0 0 1 0 0000000a 00000014 fffffff6 00001008 0
00001008 00000000 07 0 0 5 0 0 0 1 0 00000003 00000004 00000030 0000100c 0
0000100c 00000000 08 0 0 6 0 0 0 1 0 80000000 0000001f 00000001 00001010 0
00001010 00000000 09 0 0 7 0 0 0 1 0 80000000 00000004 f8000000 00001014 0
00001014 00000000 0a 0 0 8 0 0 0 1 0 ffffffff 00000001 00000001 00001018 0
00001018 00000000 0b 0 0 9 0 0 0 1 0 ffffffff 00000001 00000000 0000101c 0
0000101c 00000000 0c 0 1 2 0 0 0 1 0 0000000f 00000000 00000004 00001020 0
00001020 00000000 0d 3 0 3 0 0 0 1 0 aaaaaaaa 12345678 12345678 00001024 0
00001024 00000000 0e 0 0 4 0 0 0 1 0 ff00ff00 0ff00ff0 f0f0f0f0 00001028 0
00002000 00000100 0f 2 2 0 0 0 0 1 0 00000000 00000000 00002100 00002004 0
00002004 00abc000 10 1 2 0 0 0 0 1 1 00000000 00000000 00abc000 00002008 0
00003000 00000040 00 0 0 a 0 0 1 0 0 00000007 00000007 00000001 00003040 1
00003040 fffffff0 00 0 0 b 0 0 1 0 0 00000007 00000007 00000000 00003044 0
00003044 fffffff0 00 0 0 c 0 0 1 0 0 00000005 fffffffb 00000001 00003034 1
00003034 00000020 00 0 0 d 0 0 1 0 0 00000005 fffffffb 00000000 00003038 0
00004000 00000200 01 2 1 0 0 0 2 1 0 00000000 00000000 00004004 00004200 1
00004200 00000011 01 2 1 0 0 0 3 1 0 00005000 00000000 00004204 00005010 1
00005010 00000004 01 2 1 0 0 0 3 1 0 00005010 00000000 00005014 00005014 0
00006000 00000000 21 0 0 0 0 1 0 1 0 3fc00000 40100000 40700000 00006004 0
00006004 00000000 22 0 0 0 1 1 0 1 0 40a00000 3fa00000 40700000 00006008 0
00006008 00000000 23 0 0 0 2 1 0 1 0 40400000 bf000000 bfc00000 0000600c 0
0000600c 00000000 24 0 0 0 0 1 0 1 0 3f800000 33c00000 3f800000 00006010 0
00006010 00000000 25 0 0 0 1 1 0 1 0 40000000 40000000 00000000 00006014 0
